/* logic/mul_ctrl_fsm.sv */
// multiply control state machine
`timescale 1ns/1ps
`default_nettype none

module mul_ctrl_fsm
    import mul_ctrl_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic req_valid,
    input  logic last,
    output logic req_ready,
    output logic accept,
    output logic busy
);

    mul_state_t state_q;
    mul_state_t state_d;

    // one request in flight at most
    assign req_ready = (state_q == st_idle);
    assign accept    = req_valid & req_ready;
    assign busy      = (state_q == st_busy);

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                if (accept) begin
                    state_d = st_busy;
                end
            end
            st_busy: begin
                // leave on the edge after the final count
                if (last) begin
                    state_d = st_idle;
                end
            end
            default: begin
                state_d = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= st_idle;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

`default_nettype wire

/* logic/mul_ctrl_pkg.sv */
// multiply control definitions
`default_nettype none

package mul_ctrl_pkg;

    // ====================================================================
    // state machine
    // ====================================================================
    typedef enum logic {
        st_idle = 1'b0,
        st_busy = 1'b1
    } mul_state_t;

    // ====================================================================
    // latency
    // ====================================================================
    typedef logic [1:0] lat_cnt_t;

    // last busy cycle, result strobe fires here
    localparam lat_cnt_t lat_last = 2'd3;

endpackage

`default_nettype wire

/* logic/mul_latency_counter.sv */
// multiply latency counter
`timescale 1ns/1ps
`default_nettype none

module mul_latency_counter
    import mul_ctrl_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic accept,
    input  logic busy,
    output logic last
);

    // stands in for the pipeline depth of a real multiplier array
    lat_cnt_t cnt_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_q <= '0;
        end else if (accept) begin
            cnt_q <= '0;
        end else if (busy) begin
            // wraps back to zero on the exit edge
            cnt_q <= cnt_q + lat_cnt_t'(1);
        end
    end

    assign last = (cnt_q == lat_last);

endmodule

`default_nettype wire

/* logic/mul_operand_format.sv */
// multiply operand conditioning
`timescale 1ns/1ps
`default_nettype none

module mul_operand_format
    import mul_types_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         accept,
    input  mul_req_t     req,
    output ext_operand_t op_a,
    output ext_operand_t op_b,
    output logic         mulw_q
);

    ext_operand_t op_a_d;
    ext_operand_t op_b_d;

    // ====================================================================
    // sign extension to the 66-bit signed form
    // ====================================================================
    function automatic ext_operand_t extend_operand(
        input xword_t value,
        input logic   is_signed,
        input logic   word_mode
    );
        logic                   sign_bit;
        logic [xlen-word_w-1:0] upper;
        logic [ext_w-xlen-1:0]  guard;

        // effective sign depends on operand width
        if (word_mode) begin
            sign_bit = value[word_w-1];
        end else begin
            sign_bit = value[xlen-1];
        end

        // word mode ignores whatever sits in the upper half
        if (word_mode) begin
            upper = is_signed ? {(xlen-word_w){sign_bit}} : '0;
        end else begin
            upper = value[xlen-1:word_w];
        end

        guard = is_signed ? {(ext_w-xlen){sign_bit}} : '0;
        return {guard, upper, value[word_w-1:0]};
    endfunction

    assign op_a_d = extend_operand(req.multiplicand, req.sign_mode[1], req.mulw);
    assign op_b_d = extend_operand(req.multiplier, req.sign_mode[0], req.mulw);

    // ====================================================================
    // capture on accept
    // ====================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            op_a   <= '0;
            op_b   <= '0;
            mulw_q <= 1'b0;
        end else if (accept) begin
            op_a   <= op_a_d;
            op_b   <= op_b_d;
            mulw_q <= req.mulw;
        end
    end

endmodule

`default_nettype wire

/* logic/mul_product_stage.sv */
// multiply product stage
`timescale 1ns/1ps
`default_nettype none

module mul_product_stage
    import mul_types_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  ext_operand_t op_a,
    input  ext_operand_t op_b,
    input  logic         mulw_q,
    output mul_result_t  res
);

    wide_product_t product_q;
    // word flag kept aligned with the product it belongs to
    logic          mulw_p;
    xword_t        lo_word;
    xword_t        lo_dword;

    // ====================================================================
    // product register
    // ====================================================================
    // both operands are sign-correct after conditioning, so one
    // signed multiply covers every sign combination
    always_ff @(posedge clk) begin
        if (rst) begin
            product_q <= '0;
            mulw_p    <= 1'b0;
        end else begin
            product_q <= op_a * op_b;
            mulw_p    <= mulw_q;
        end
    end

    // ====================================================================
    // result forming
    // ====================================================================
    assign lo_dword = product_q[xlen-1:0];

    // W-form result is the low word sign-extended
    assign lo_word = {{(xlen-word_w){product_q[word_w-1]}}, product_q[word_w-1:0]};

    always_comb begin
        res.hi = product_q[2*xlen-1:xlen];
        if (mulw_p) begin
            res.lo = lo_word;
        end else begin
            res.lo = lo_dword;
        end
    end

endmodule

`default_nettype wire

/* logic/mul_types_pkg.sv */
// multiply datapath types
`default_nettype none

package mul_types_pkg;

    // ====================================================================
    // widths
    // ====================================================================
    localparam int xlen   = 64;
    localparam int word_w = 32;
    // two guard bits so unsigned 64-bit operands stay positive
    localparam int ext_w  = 66;
    localparam int prod_w = 2 * ext_w;

    // ====================================================================
    // vector types
    // ====================================================================
    typedef logic [xlen-1:0]          xword_t;
    typedef logic signed [ext_w-1:0]  ext_operand_t;
    typedef logic signed [prod_w-1:0] wide_product_t;

    // [1] multiplicand signed, [0] multiplier signed
    typedef logic [1:0] sign_mode_t;

    // ====================================================================
    // request and result
    // ====================================================================
    typedef struct packed {
        logic       mulw;
        sign_mode_t sign_mode;
        xword_t     multiplicand;
        xword_t     multiplier;
    } mul_req_t;

    typedef struct packed {
        xword_t hi;
        xword_t lo;
    } mul_result_t;

endpackage

`default_nettype wire

/* logic/mul_unit.sv */
// integer multiply unit
`timescale 1ns/1ps
`default_nettype none

module mul_unit
    import mul_types_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    // request side
    input  logic        req_valid,
    input  mul_req_t    req,
    output logic        req_ready,

    // result side, no back-pressure
    output logic        res_valid,
    output mul_result_t res
);

    logic         accept;
    logic         busy;
    logic         last;
    ext_operand_t op_a;
    ext_operand_t op_b;
    logic         mulw_q;

    // ====================================================================
    // control
    // ====================================================================
    mul_ctrl_fsm u_ctrl_fsm (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .last      (last),
        .req_ready (req_ready),
        .accept    (accept),
        .busy      (busy)
    );

    mul_latency_counter u_latency_counter (
        .clk    (clk),
        .rst    (rst),
        .accept (accept),
        .busy   (busy),
        .last   (last)
    );

    // strobe on the final busy cycle
    assign res_valid = last;

    // ====================================================================
    // datapath
    // ====================================================================
    mul_operand_format u_operand_format (
        .clk    (clk),
        .rst    (rst),
        .accept (accept),
        .req    (req),
        .op_a   (op_a),
        .op_b   (op_b),
        .mulw_q (mulw_q)
    );

    mul_product_stage u_product_stage (
        .clk    (clk),
        .rst    (rst),
        .op_a   (op_a),
        .op_b   (op_b),
        .mulw_q (mulw_q),
        .res    (res)
    );

endmodule

`default_nettype wire

/* include/mul_tb_checks.svh */
// multiply testbench checks
`ifndef mul_tb_checks_svh
`define mul_tb_checks_svh

// ======================================================================
// error counters
// ======================================================================
int unsigned value_errors = 0;
int unsigned other_errors = 0;

// hi and lo reported on their own lines
task automatic check_result(input mul_result_t got, input mul_result_t want);
    if (got.hi !== want.hi) begin
        $display("error: res.hi got %h expected %h at %0t", got.hi, want.hi, $time);
        value_errors++;
    end
    if (got.lo !== want.lo) begin
        $display("error: res.lo got %h expected %h at %0t", got.lo, want.lo, $time);
        value_errors++;
    end
endtask

task automatic check_bit(input string name, input logic got, input logic want);
    if (got !== want) begin
        $display("error: %s got %h expected %h at %0t", name, got, want, $time);
        value_errors++;
    end
endtask

// anything that is not a plain value mismatch
task automatic report_failure(input string what);
    $display("%s at %0t", what, $time);
    other_errors++;
endtask

`endif

/* test/mul_unit_tb.sv */
// multiply unit testbench
`timescale 1ns/1ps
`default_nettype none

module mul_unit_tb
    import mul_types_pkg::*;
;

    `include "mul_tb_checks.svh"

    localparam int n_random = 200;

    logic        clk;
    logic        rst;
    logic        req_valid;
    mul_req_t    req;
    logic        req_ready;
    logic        res_valid;
    mul_result_t res;

    mul_req_t    dir_req[$];
    mul_result_t dir_exp[$];
    mul_result_t exp_q[$];

    logic [31:0] lfsr_state = 32'hec7d_5bd1;
    int unsigned cyc        = 0;
    int unsigned acc_cyc    = 0;
    logic        pending    = 1'b0;
    int unsigned n_done     = 0;

    mul_unit dut0 (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .res_valid (res_valid),
        .res       (res)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ======================================================================
    // stimulus helpers
    // ======================================================================
    function automatic logic next_bit();
        logic out;
        out        = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return out;
    endfunction

    function automatic xword_t rand_bits(input int n);
        xword_t v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v[k] = next_bit();
        end
        return v;
    endfunction

    task automatic random_req(output mul_req_t r);
        xword_t bits;
        bits           = rand_bits(1);
        r.mulw         = bits[0];
        bits           = rand_bits(2);
        r.sign_mode    = bits[1:0];
        r.multiplicand = rand_bits(xlen);
        r.multiplier   = rand_bits(xlen);
    endtask

    task automatic add_row(input logic w, input sign_mode_t sm, input xword_t a, input xword_t b,
                           input xword_t hi, input xword_t lo);
        mul_req_t    r;
        mul_result_t e;
        r.mulw         = w;
        r.sign_mode    = sm;
        r.multiplicand = a;
        r.multiplier   = b;
        e.hi           = hi;
        e.lo           = lo;
        dir_req.push_back(r);
        dir_exp.push_back(e);
    endtask

    // ======================================================================
    // reference model
    // ======================================================================
    function automatic ext_operand_t condition(input xword_t v, input logic is_signed,
                                               input logic word_mode);
        ext_operand_t x;
        if (word_mode && is_signed) begin
            x = $signed(v[word_w-1:0]);
        end else if (word_mode) begin
            x = {{(ext_w-word_w){1'b0}}, v[word_w-1:0]};
        end else if (is_signed) begin
            x = $signed(v);
        end else begin
            x = {{(ext_w-xlen){1'b0}}, v};
        end
        return x;
    endfunction

    function automatic mul_result_t model_result(input mul_req_t r);
        ext_operand_t  a;
        ext_operand_t  b;
        wide_product_t p;
        mul_result_t   e;
        a    = condition(r.multiplicand, r.sign_mode[1], r.mulw);
        b    = condition(r.multiplier, r.sign_mode[0], r.mulw);
        p    = a * b;
        e.hi = p[2*xlen-1:xlen];
        if (r.mulw) begin
            e.lo = $signed(p[word_w-1:0]);
        end else begin
            e.lo = p[xlen-1:0];
        end
        return e;
    endfunction

    task automatic build_table();
        add_row(1'b0, 2'b00, 64'hffff_ffff_ffff_ffff, 64'hffff_ffff_ffff_ffff,
                64'hffff_ffff_ffff_fffe, 64'h0000_0000_0000_0001);
        add_row(1'b0, 2'b11, 64'hffff_ffff_ffff_ffff, 64'hffff_ffff_ffff_ffff,
                64'h0000_0000_0000_0000, 64'h0000_0000_0000_0001);
        add_row(1'b0, 2'b10, 64'hffff_ffff_ffff_fffe, 64'h0000_0000_0000_0003,
                64'hffff_ffff_ffff_ffff, 64'hffff_ffff_ffff_fffa);
        add_row(1'b0, 2'b10, 64'h8000_0000_0000_0000, 64'h0000_0000_0000_0002,
                64'hffff_ffff_ffff_ffff, 64'h0000_0000_0000_0000);
        add_row(1'b0, 2'b11, 64'h0000_0000_0000_0000, 64'hffff_ffff_ffff_ffff,
                64'h0000_0000_0000_0000, 64'h0000_0000_0000_0000);
        add_row(1'b0, 2'b00, 64'h0000_0001_0000_0000, 64'h0000_0001_0000_0000,
                64'h0000_0000_0000_0001, 64'h0000_0000_0000_0000);
        add_row(1'b0, 2'b11, 64'h8000_0000_0000_0000, 64'h8000_0000_0000_0000,
                64'h4000_0000_0000_0000, 64'h0000_0000_0000_0000);
        // word mode with garbage in the upper halves
        add_row(1'b1, 2'b11, 64'hdead_beef_0000_0003, 64'h1234_5678_0000_0005,
                64'h0000_0000_0000_0000, 64'h0000_0000_0000_000f);
        add_row(1'b1, 2'b11, 64'haaaa_aaaa_0000_8000, 64'h5555_5555_0001_0000,
                64'h0000_0000_0000_0000, 64'hffff_ffff_8000_0000);
        add_row(1'b1, 2'b11, 64'hffff_0000_ffff_ffff, 64'h1234_0000_0000_0007,
                64'hffff_ffff_ffff_ffff, 64'hffff_ffff_ffff_fff9);
        add_row(1'b1, 2'b00, 64'h1111_1111_ffff_ffff, 64'h2222_2222_0000_0002,
                64'h0000_0000_0000_0000, 64'hffff_ffff_ffff_fffe);
    endtask

    // entered 1 ns after a rising edge and left 1 ns after the unit is idle again
    task automatic issue(input mul_req_t r, input mul_result_t want);
        mul_req_t junk;
        req_valid = 1'b1;
        req       = r;
        exp_q.push_back(want);
        @(negedge clk);
        while (!req_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        // keep valid high and scramble the operands while busy
        while (!req_ready) begin
            random_req(junk);
            req = junk;
            @(posedge clk);
            #1;
        end
    endtask

    // ======================================================================
    // response monitor
    // ======================================================================
    always @(posedge clk) begin
        cyc = cyc + 1;
    end

    always @(negedge clk) begin : monitor
        mul_result_t want;
        if (!rst) begin
            if (pending) begin
                check_bit("res_valid", res_valid, cyc == acc_cyc + 4);
                check_bit("req_ready", req_ready, 1'b0);
                if (cyc == acc_cyc + 4) begin
                    want = exp_q.pop_front();
                    check_result(res, want);
                    pending = 1'b0;
                    n_done++;
                end
            end else begin
                check_bit("res_valid", res_valid, 1'b0);
                check_bit("req_ready", req_ready, 1'b1);
            end
            if (req_valid && req_ready) begin
                pending = 1'b1;
                acc_cyc = cyc;
            end
        end
    end

    // ======================================================================
    // main sequence
    // ======================================================================
    initial begin : stimulus
        mul_req_t r;
        rst       = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        build_table();
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        // idle cycles so the monitor sees the post-reset outputs
        repeat (3) @(posedge clk);
        #1;
        for (int i = 0; i < dir_req.size(); i++) begin
            issue(dir_req[i], dir_exp[i]);
        end
        for (int i = 0; i < n_random; i++) begin
            random_req(r);
            issue(r, model_result(r));
        end
        req_valid = 1'b0;
        req       = '0;
        wait (n_done == dir_req.size() + n_random);
        repeat (4) @(posedge clk);
        $display("errors: %0d value, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin : watchdog
        int unsigned limit;
        #1;
        limit = (dir_req.size() + n_random) * 8 + 200;
        repeat (limit) @(posedge clk);
        report_failure("run timed out with results still missing");
        $display("errors: %0d value, %0d other", value_errors, other_errors);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+include
logic/mul_types_pkg.sv
logic/mul_ctrl_pkg.sv
logic/mul_ctrl_fsm.sv
logic/mul_latency_counter.sv
logic/mul_operand_format.sv
logic/mul_product_stage.sv
logic/mul_unit.sv
test/mul_unit_tb.sv
